//--- src/soc_consts.svh
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

////////////////////////////////////////
// Data RAM
////////////////////////////////////////

// Depth in 32-bit words
`define SOC_RAM_WORDS 256
// Word index width
`define SOC_RAM_AW 8
// One kilobyte window at the bottom of the map
`define SOC_RAM_BASE 32'h0000_0000
`define SOC_RAM_BYTES 32'h0000_0400

////////////////////////////////////////
// Serial transmitter
////////////////////////////////////////

// Write only, low byte goes out on txd
`define SOC_UART_DATA 32'h0000_1000
// Read only: full, empty, LED flags in bits 4..2
`define SOC_UART_STAT 32'h0000_1004
`define SOC_TX_FIFO_DEPTH 8
// Clocks per serial bit
`define SOC_BAUD_DIV 16

`endif

//--- src/soc_pkg.sv
package soc_pkg;

	////////////////////////////////////////
	// Plain vectors
	////////////////////////////////////////

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0] strb_t;
	typedef logic [7:0] byte_t;
	// Sticky flags for '0', '1' and line feed
	typedef logic [2:0] led_t;

	////////////////////////////////////////
	// Encodings and FSM states
	////////////////////////////////////////

	typedef enum logic [1:0] {
		OKAY = 2'd0,
		SLVERR = 2'd2,
		DECERR = 2'd3
	} axil_resp_e;

	// Bus-side port FSM
	typedef enum logic [1:0] {
		PS_IDLE,
		PS_WAIT,
		PS_RESP
	} port_state_e;

	// Serializer FSM
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

	////////////////////////////////////////
	// Bus bundles
	////////////////////////////////////////

	// Master side of AXI4-Lite
	typedef struct packed {
		logic awvalid;
		addr_t awaddr;
		logic wvalid;
		data_t wdata;
		strb_t wstrb;
		logic bready;
		logic arvalid;
		addr_t araddr;
		logic rready;
	} axil_req_t;

	// Slave side of AXI4-Lite
	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		axil_resp_e bresp;
		logic arready;
		logic rvalid;
		data_t rdata;
		axil_resp_e rresp;
	} axil_rsp_t;

	// Internal single-request bus
	typedef struct packed {
		logic valid;
		logic we;
		addr_t addr;
		data_t wdata;
		strb_t wstrb;
	} bus_req_t;

	typedef struct packed {
		logic done;
		data_t rdata;
		axil_resp_e resp;
	} bus_rsp_t;

endpackage

//--- src/axil_slave_port.sv
`timescale 1ns/10ps

module axil_slave_port (
	input logic clk,
	input logic rst,
	input soc_pkg::axil_req_t axil_req,
	output soc_pkg::axil_rsp_t axil_rsp,
	output soc_pkg::bus_req_t bus_req,
	input soc_pkg::bus_rsp_t bus_rsp
);

	soc_pkg::port_state_e state;
	soc_pkg::port_state_e state_n;

	// Channel handshake flags
	logic ar_rdy;
	logic aw_rdy;
	logic bvalid;
	logic rvalid;
	logic req_valid;
	logic take_rd;
	logic take_wr;
	logic b_hs;
	logic r_hs;
	logic rsp_done;

	// Latched request and response payload
	logic we_q;
	soc_pkg::addr_t addr_q;
	soc_pkg::data_t wdata_q;
	soc_pkg::strb_t wstrb_q;
	soc_pkg::axil_resp_e resp_q;
	soc_pkg::data_t rdata_q;

	// Read wins when both kinds are pending
	assign take_rd = (state == soc_pkg::PS_IDLE) && ar_rdy && axil_req.arvalid;
	assign take_wr = (state == soc_pkg::PS_IDLE) && ar_rdy && !axil_req.arvalid &&
		axil_req.awvalid && axil_req.wvalid;
	assign b_hs = bvalid && axil_req.bready;
	assign r_hs = rvalid && axil_req.rready;
	assign rsp_done = (state == soc_pkg::PS_WAIT) && bus_rsp.done;

	////////////////////////////////////////
	// Next state
	////////////////////////////////////////

	always_comb begin
		state_n = state;
		case (state)
			soc_pkg::PS_IDLE: begin
				if (take_rd || take_wr)
					state_n = soc_pkg::PS_WAIT;
			end
			soc_pkg::PS_WAIT: begin
				if (bus_rsp.done)
					state_n = soc_pkg::PS_RESP;
			end
			soc_pkg::PS_RESP: begin
				// Held here until the master takes B or R
				if (b_hs || r_hs)
					state_n = soc_pkg::PS_IDLE;
			end
			default: state_n = soc_pkg::PS_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= soc_pkg::PS_IDLE;
			ar_rdy <= 1'b0;
			aw_rdy <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			req_valid <= 1'b0;
		end else begin
			state <= state_n;
			// arready follows IDLE, low in the first cycle out of reset
			ar_rdy <= (state_n == soc_pkg::PS_IDLE);
			// AW and W taken together, one cycle late
			aw_rdy <= take_wr;
			if (take_rd || take_wr)
				req_valid <= 1'b1;
			else if (bus_rsp.done)
				req_valid <= 1'b0;
			if (rsp_done) begin
				bvalid <= we_q;
				rvalid <= !we_q;
			end else begin
				if (b_hs)
					bvalid <= 1'b0;
				if (r_hs)
					rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_rd) begin
			we_q <= 1'b0;
			addr_q <= axil_req.araddr;
			wstrb_q <= '0;
		end else if (take_wr) begin
			we_q <= 1'b1;
			addr_q <= axil_req.awaddr;
			wdata_q <= axil_req.wdata;
			wstrb_q <= axil_req.wstrb;
		end
		if (rsp_done) begin
			resp_q <= bus_rsp.resp;
			rdata_q <= bus_rsp.rdata;
		end
	end

	// Channel outputs
	assign axil_rsp.awready = aw_rdy;
	assign axil_rsp.wready = aw_rdy;
	assign axil_rsp.bvalid = bvalid;
	assign axil_rsp.bresp = resp_q;
	assign axil_rsp.arready = ar_rdy;
	assign axil_rsp.rvalid = rvalid;
	assign axil_rsp.rdata = rdata_q;
	assign axil_rsp.rresp = resp_q;

	// Internal request
	assign bus_req.valid = req_valid;
	assign bus_req.we = we_q;
	assign bus_req.addr = addr_q;
	assign bus_req.wdata = wdata_q;
	assign bus_req.wstrb = wstrb_q;

endmodule

//--- src/mem_map_unit.sv
`timescale 1ns/10ps
`include "soc_consts.svh"

module mem_map_unit (
	input logic clk,
	input logic rst,
	input soc_pkg::bus_req_t bus_req,
	output soc_pkg::bus_rsp_t bus_rsp,
	output logic ram_en,
	output soc_pkg::strb_t ram_we,
	output logic [`SOC_RAM_AW-1:0] ram_addr,
	output soc_pkg::data_t ram_wdata,
	input soc_pkg::data_t ram_rdata,
	output logic tx_push,
	output soc_pkg::byte_t tx_byte,
	input logic tx_full,
	input logic tx_empty,
	input soc_pkg::led_t led
);

	soc_pkg::addr_t ram_off;
	soc_pkg::addr_t word_addr;
	logic is_ram;
	logic is_data;
	logic is_stat;
	logic stall;
	logic issue;
	logic busy;
	logic rd_pend;
	logic done_q;
	// Read source registered at issue
	logic sel_ram;
	logic sel_stat;
	soc_pkg::axil_resp_e resp_c;
	soc_pkg::axil_resp_e resp_q;
	soc_pkg::data_t stat_word;
	soc_pkg::data_t rdata_q;

	////////////////////////////////////////
	// Address decode
	////////////////////////////////////////

	assign ram_off = bus_req.addr - `SOC_RAM_BASE;
	assign word_addr = {bus_req.addr[31:2], 2'b00};
	assign is_ram = ram_off < `SOC_RAM_BYTES;
	assign is_data = (word_addr == `SOC_UART_DATA);
	assign is_stat = (word_addr == `SOC_UART_STAT);

	// Wrong direction on a UART register gives SLVERR, holes give DECERR
	always_comb begin
		if (is_ram)
			resp_c = soc_pkg::OKAY;
		else if (is_data)
			resp_c = bus_req.we ? soc_pkg::OKAY : soc_pkg::SLVERR;
		else if (is_stat)
			resp_c = bus_req.we ? soc_pkg::SLVERR : soc_pkg::OKAY;
		else
			resp_c = soc_pkg::DECERR;
	end

	// Hold a data write back while the FIFO has no room
	assign stall = bus_req.we && is_data && tx_full;
	assign issue = bus_req.valid && !busy && !stall;

	// One-cycle strobes
	assign ram_en = issue && is_ram;
	assign ram_we = (issue && bus_req.we && is_ram) ? bus_req.wstrb : '0;
	assign ram_addr = ram_off[`SOC_RAM_AW+1:2];
	assign ram_wdata = bus_req.wdata;
	assign tx_push = issue && bus_req.we && is_data;
	assign tx_byte = bus_req.wdata[7:0];

	assign stat_word = {27'd0, led, tx_empty, tx_full};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy <= 1'b0;
			rd_pend <= 1'b0;
			done_q <= 1'b0;
		end else begin
			if (issue)
				busy <= 1'b1;
			else if (done_q)
				busy <= 1'b0;
			rd_pend <= issue && !bus_req.we;
			// Writes finish next cycle, reads wait for the RAM register
			done_q <= (issue && bus_req.we) || rd_pend;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			sel_ram <= is_ram;
			sel_stat <= is_stat;
			resp_q <= resp_c;
		end
		// Read mux, zero for holes and the data address
		if (rd_pend) begin
			if (sel_ram)
				rdata_q <= ram_rdata;
			else if (sel_stat)
				rdata_q <= stat_word;
			else
				rdata_q <= '0;
		end
	end

	assign bus_rsp.done = done_q;
	assign bus_rsp.rdata = rdata_q;
	assign bus_rsp.resp = resp_q;

endmodule

//--- src/data_ram.sv
`timescale 1ns/10ps
`include "soc_consts.svh"

module data_ram (
	input logic clk,
	input logic en,
	input soc_pkg::strb_t we,
	input logic [`SOC_RAM_AW-1:0] addr,
	input soc_pkg::data_t wdata,
	output soc_pkg::data_t rdata
);

	////////////////////////////////////////
	// Word array with byte lanes
	////////////////////////////////////////

	soc_pkg::data_t mem [`SOC_RAM_WORDS];

	always_ff @(posedge clk) begin
		if (en) begin
			// Each strobe bit owns one byte lane
			for (int i = 0; i < 4; i++) begin
				if (we[i])
					mem[addr][8*i +: 8] <= wdata[8*i +: 8];
			end
			// Old word on a write, result unused then
			rdata <= mem[addr];
		end
	end

endmodule

//--- src/uart_tx_fifo.sv
`timescale 1ns/10ps
`include "soc_consts.svh"

module uart_tx_fifo (
	input logic clk,
	input logic rst,
	input logic push,
	input soc_pkg::byte_t din,
	output logic full,
	output logic empty,
	output logic txd
);

	localparam int PTR_W = $clog2(`SOC_TX_FIFO_DEPTH);
	localparam int CNT_W = $clog2(`SOC_TX_FIFO_DEPTH + 1);
	localparam int BAUD_W = $clog2(`SOC_BAUD_DIV);

	soc_pkg::byte_t fifo_mem [`SOC_TX_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push_ok;
	logic pop;

	soc_pkg::tx_state_e state;
	logic [BAUD_W-1:0] baud_cnt;
	logic [2:0] bit_idx;
	logic bit_end;
	soc_pkg::byte_t shreg;

	////////////////////////////////////////
	// Circular buffer
	////////////////////////////////////////

	assign full = (count == CNT_W'(`SOC_TX_FIFO_DEPTH));
	assign empty = (count == '0);
	// Push while full is dropped
	assign push_ok = push && !full;
	// Head leaves only when the line is idle
	assign pop = (state == soc_pkg::TX_IDLE) && !empty;

	always_ff @(posedge clk) begin
		if (push_ok)
			fifo_mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_ok, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////////////////////////
	// 8N1 serializer
	////////////////////////////////////////

	assign bit_end = (baud_cnt == BAUD_W'(`SOC_BAUD_DIV - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= soc_pkg::TX_IDLE;
			baud_cnt <= '0;
			bit_idx <= '0;
			txd <= 1'b1;
		end else begin
			case (state)
				soc_pkg::TX_IDLE: begin
					txd <= 1'b1;
					if (pop) begin
						state <= soc_pkg::TX_START;
						baud_cnt <= '0;
						txd <= 1'b0;
					end
				end
				soc_pkg::TX_START: begin
					if (bit_end) begin
						state <= soc_pkg::TX_DATA;
						baud_cnt <= '0;
						bit_idx <= '0;
						txd <= shreg[0];
					end else
						baud_cnt <= baud_cnt + 1'b1;
				end
				soc_pkg::TX_DATA: begin
					if (bit_end) begin
						baud_cnt <= '0;
						if (bit_idx == 3'd7) begin
							state <= soc_pkg::TX_STOP;
							txd <= 1'b1;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							// Next bit, ahead of the shift
							txd <= shreg[1];
						end
					end else
						baud_cnt <= baud_cnt + 1'b1;
				end
				soc_pkg::TX_STOP: begin
					if (bit_end)
						state <= soc_pkg::TX_IDLE;
					else
						baud_cnt <= baud_cnt + 1'b1;
				end
				default: state <= soc_pkg::TX_IDLE;
			endcase
		end
	end

	// LSB first
	always_ff @(posedge clk) begin
		if (pop)
			shreg <= fifo_mem[rd_ptr];
		else if (state == soc_pkg::TX_DATA && bit_end)
			shreg <= shreg >> 1;
	end

endmodule

//--- src/char_led_monitor.sv
`timescale 1ns/10ps

module char_led_monitor (
	input logic clk,
	input logic rst,
	input logic push,
	input soc_pkg::byte_t din,
	input logic full,
	output soc_pkg::led_t led
);

	// ASCII codes that light the board LEDs
	localparam soc_pkg::byte_t CH_ZERO = 8'h30;
	localparam soc_pkg::byte_t CH_ONE = 8'h31;
	localparam soc_pkg::byte_t CH_LF = 8'h0a;

	logic accept;

	// Only bytes the FIFO really takes
	assign accept = push && !full;

	////////////////////////////////////////
	// Sticky flags, cleared by reset only
	////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			led <= '0;
		end else if (accept) begin
			if (din == CH_ZERO)
				led[0] <= 1'b1;
			if (din == CH_ONE)
				led[1] <= 1'b1;
			if (din == CH_LF)
				led[2] <= 1'b1;
		end
	end

endmodule

//--- src/soc_top.sv
`timescale 1ns/10ps
`include "soc_consts.svh"

module soc_top (
	input logic clk,
	input logic rst,
	input soc_pkg::axil_req_t axil_req,
	output soc_pkg::axil_rsp_t axil_rsp,
	output soc_pkg::led_t led,
	output logic txd
);

	// Port to decoder
	soc_pkg::bus_req_t bus_req;
	soc_pkg::bus_rsp_t bus_rsp;

	// Decoder to RAM
	logic ram_en;
	soc_pkg::strb_t ram_we;
	logic [`SOC_RAM_AW-1:0] ram_addr;
	soc_pkg::data_t ram_wdata;
	soc_pkg::data_t ram_rdata;

	// Decoder to transmit FIFO
	logic tx_push;
	soc_pkg::byte_t tx_byte;
	logic tx_full;
	logic tx_empty;

	////////////////////////////////////////
	// Bus side
	////////////////////////////////////////

	axil_slave_port u_axil_slave_port (
		.clk(clk),
		.rst(rst),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp)
	);

	mem_map_unit u_mem_map_unit (
		.clk(clk),
		.rst(rst),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp),
		.ram_en(ram_en),
		.ram_we(ram_we),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata),
		.tx_push(tx_push),
		.tx_byte(tx_byte),
		.tx_full(tx_full),
		.tx_empty(tx_empty),
		.led(led)
	);

	////////////////////////////////////////
	// Targets
	////////////////////////////////////////

	data_ram u_data_ram (
		.clk(clk),
		.en(ram_en),
		.we(ram_we),
		.addr(ram_addr),
		.wdata(ram_wdata),
		.rdata(ram_rdata)
	);

	uart_tx_fifo u_uart_tx_fifo (
		.clk(clk),
		.rst(rst),
		.push(tx_push),
		.din(tx_byte),
		.full(tx_full),
		.empty(tx_empty),
		.txd(txd)
	);

	// LEDs also feed the status word
	char_led_monitor u_char_led_monitor (
		.clk(clk),
		.rst(rst),
		.push(tx_push),
		.din(tx_byte),
		.full(tx_full),
		.led(led)
	);

endmodule

//--- tb/soc_tb.sv
`timescale 1ns/10ps
`include "soc_consts.svh"

module soc_tb;

	// One serial bit in ns at the 4 ns clock
	localparam int BIT_NS = `SOC_BAUD_DIV * 4;
	// Bytes put on the line by the frame, back-pressure, status and LED tests
	localparam int TX_BYTES = 1 + 12 + (`SOC_TX_FIFO_DEPTH + 1) + 4;
	localparam int WATCHDOG_NS = TX_BYTES * 10 * BIT_NS + 2000;
	localparam int unsigned SEED = 32'h5801bdc1;

	logic clk;
	logic rst;
	soc_pkg::axil_req_t axil_req;
	soc_pkg::axil_rsp_t axil_rsp;
	soc_pkg::led_t led;
	logic txd;

	// Expected RAM words and the addresses under test
	soc_pkg::data_t ram_model [`SOC_RAM_WORDS];
	soc_pkg::addr_t test_addr [8];
	// Bytes sent and bytes seen on txd
	soc_pkg::byte_t tx_q [$];
	soc_pkg::byte_t rx_q [$];

	initial clk = 1'b0;
	always #2 clk = ~clk;

	soc_top u_soc_top (
		.clk(clk),
		.rst(rst),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.led(led),
		.txd(txd)
	);

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic check_data(input string name, input soc_pkg::data_t exp,
			input soc_pkg::data_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			$display("Checks failed");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic check_resp(input string name, input soc_pkg::axil_resp_e exp,
			input soc_pkg::axil_resp_e act);
		if (act !== exp) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			$display("Checks failed");
			$fatal(1, "response mismatch");
		end
	endtask

	task automatic check_byte(input string name, input soc_pkg::byte_t exp,
			input soc_pkg::byte_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			$display("Checks failed");
			$fatal(1, "byte mismatch");
		end
	endtask

	task automatic check_led(input string name, input soc_pkg::led_t exp,
			input soc_pkg::led_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
			$display("Checks failed");
			$fatal(1, "LED mismatch");
		end
	endtask

	////////////////////////////////////////
	// Bus and serial helpers
	////////////////////////////////////////

	// Inputs change just after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#0.5;
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (2) next_cycle();
		rst = 1'b0;
	endtask

	task automatic axil_write(input soc_pkg::addr_t addr, input soc_pkg::data_t data,
			input soc_pkg::strb_t strb, output soc_pkg::axil_resp_e resp);
		logic hs;
		axil_req.awvalid = 1'b1;
		axil_req.awaddr = addr;
		axil_req.wvalid = 1'b1;
		axil_req.wdata = data;
		axil_req.wstrb = strb;
		axil_req.bready = 1'b1;
		// Ready seen now means transfer at the next edge
		do begin
			hs = axil_rsp.awready && axil_rsp.wready;
			next_cycle();
		end while (!hs);
		axil_req.awvalid = 1'b0;
		axil_req.wvalid = 1'b0;
		// Latency varies while the FIFO is full
		do begin
			hs = axil_rsp.bvalid;
			resp = axil_rsp.bresp;
			next_cycle();
		end while (!hs);
		axil_req.bready = 1'b0;
	endtask

	task automatic axil_read(input soc_pkg::addr_t addr, output soc_pkg::data_t data,
			output soc_pkg::axil_resp_e resp);
		logic hs;
		axil_req.arvalid = 1'b1;
		axil_req.araddr = addr;
		axil_req.rready = 1'b1;
		do begin
			hs = axil_rsp.arready;
			next_cycle();
		end while (!hs);
		axil_req.arvalid = 1'b0;
		do begin
			hs = axil_rsp.rvalid;
			data = axil_rsp.rdata;
			resp = axil_rsp.rresp;
			next_cycle();
		end while (!hs);
		axil_req.rready = 1'b0;
	endtask

	// 8N1 decode sampled mid-bit away from the clock edges
	task automatic uart_rx_byte(output soc_pkg::byte_t b);
		@(negedge txd);
		#(BIT_NS / 2 + 1);
		if (txd !== 1'b0) begin
			$display("Start bit on txd went high before mid-bit");
			$display("Checks failed");
			$fatal(1, "serial framing");
		end
		// LSB first
		for (int i = 0; i < 8; i++) begin
			#(BIT_NS);
			b[i] = txd;
		end
		#(BIT_NS);
		if (txd !== 1'b1) begin
			$display("Stop bit on txd was low");
			$display("Checks failed");
			$fatal(1, "serial framing");
		end
	endtask

	task automatic receive_bytes(input int n);
		soc_pkg::byte_t b;
		repeat (n) begin
			uart_rx_byte(b);
			rx_q.push_back(b);
		end
	endtask

	// Writes every queued byte to the data register and expects OKAY for each
	task automatic send_bytes(input string name);
		soc_pkg::axil_resp_e r;
		foreach (tx_q[i]) begin
			axil_write(`SOC_UART_DATA, {24'd0, tx_q[i]}, 4'h1, r);
			check_resp(name, soc_pkg::OKAY, r);
		end
	endtask

	task automatic fill_tx_queue(input int n);
		tx_q.delete();
		rx_q.delete();
		repeat (n)
			tx_q.push_back(soc_pkg::byte_t'($urandom));
	endtask

	task automatic compare_rx(input string name);
		foreach (tx_q[i])
			check_byte(name, tx_q[i], rx_q[i]);
	endtask

	function automatic soc_pkg::data_t merge_lanes(input soc_pkg::data_t old_word,
			input soc_pkg::data_t new_word, input soc_pkg::strb_t strb);
		soc_pkg::data_t res;
		res = old_word;
		for (int i = 0; i < 4; i++) begin
			if (strb[i])
				res[8*i +: 8] = new_word[8*i +: 8];
		end
		return res;
	endfunction

	task automatic check_ram(input string name);
		soc_pkg::data_t d;
		soc_pkg::axil_resp_e r;
		foreach (test_addr[i]) begin
			axil_read(test_addr[i], d, r);
			check_resp(name, soc_pkg::OKAY, r);
			check_data(name, ram_model[test_addr[i][9:2]], d);
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic test_ram_access();
		soc_pkg::data_t d;
		soc_pkg::strb_t s;
		soc_pkg::axil_resp_e r;
		int unsigned w;
		// Full words first so no lane stays undefined
		foreach (test_addr[i]) begin
			// Slot 1 is the word a status write hits if the upper address bits are ignored
			if (i == 1)
				w = (`SOC_UART_STAT % `SOC_RAM_BYTES) / 4;
			else
				w = $urandom_range(`SOC_RAM_WORDS - 1, 0);
			test_addr[i] = soc_pkg::addr_t'(w * 4);
			d = $urandom;
			axil_write(test_addr[i], d, 4'hf, r);
			check_resp("ram full write", soc_pkg::OKAY, r);
			ram_model[w] = d;
		end
		check_ram("ram full readback");
		foreach (test_addr[i]) begin
			d = $urandom;
			s = soc_pkg::strb_t'($urandom_range(15, 0));
			axil_write(test_addr[i], d, s, r);
			check_resp("ram partial write", soc_pkg::OKAY, r);
			ram_model[test_addr[i][9:2]] =
				merge_lanes(ram_model[test_addr[i][9:2]], d, s);
		end
		check_ram("ram partial readback");
	endtask

	task automatic test_addr_errors();
		soc_pkg::data_t d;
		soc_pkg::axil_resp_e r;
		axil_read(32'h0000_2000, d, r);
		check_resp("unmapped read", soc_pkg::DECERR, r);
		check_data("unmapped read data", 32'h0, d);
		// Aliases a RAM word in the low index bits
		axil_write(32'h0000_0400 + test_addr[0], 32'hdead_beef, 4'hf, r);
		check_resp("unmapped write", soc_pkg::DECERR, r);
		axil_write(`SOC_UART_STAT, 32'hffff_ffff, 4'hf, r);
		check_resp("status write", soc_pkg::SLVERR, r);
		axil_read(`SOC_UART_DATA, d, r);
		check_resp("data read", soc_pkg::SLVERR, r);
		check_data("data read value", 32'h0, d);
		check_ram("ram after errors");
	endtask

	task automatic test_serial_frame();
		soc_pkg::data_t d;
		soc_pkg::axil_resp_e r;
		fill_tx_queue(1);
		fork
			send_bytes("serial frame write");
			receive_bytes(1);
		join
		compare_rx("serial frame");
		// Empty set and full clear
		axil_read(`SOC_UART_STAT, d, r);
		check_resp("status after frame", soc_pkg::OKAY, r);
		check_data("status after frame", 32'h2, d & 32'h3);
	endtask

	task automatic test_back_pressure();
		fill_tx_queue(12);
		fork
			send_bytes("back-pressure write");
			receive_bytes(12);
		join
		compare_rx("back-pressure order");
	endtask

	task automatic test_status_flags();
		soc_pkg::data_t d;
		soc_pkg::axil_resp_e r;
		fill_tx_queue(`SOC_TX_FIFO_DEPTH + 1);
		fork
			begin
				send_bytes("status fill write");
				axil_read(`SOC_UART_STAT, d, r);
				check_resp("status full read", soc_pkg::OKAY, r);
				check_data("status full", 32'h1, d & 32'h3);
			end
			receive_bytes(`SOC_TX_FIFO_DEPTH + 1);
		join
		compare_rx("status fill bytes");
		axil_read(`SOC_UART_STAT, d, r);
		check_resp("status drained read", soc_pkg::OKAY, r);
		check_data("status drained", 32'h2, d & 32'h3);
	endtask

	task automatic test_led_flags();
		soc_pkg::data_t d;
		soc_pkg::axil_resp_e r;
		// Random bytes earlier may have lit LEDs
		apply_reset();
		check_led("led after first reset", 3'b000, led);
		axil_write(`SOC_UART_DATA, 32'h41, 4'h1, r);
		check_resp("led write A", soc_pkg::OKAY, r);
		check_led("led after A", 3'b000, led);
		axil_write(`SOC_UART_DATA, 32'h30, 4'h1, r);
		check_resp("led write 0", soc_pkg::OKAY, r);
		check_led("led after 0", 3'b001, led);
		axil_write(`SOC_UART_DATA, 32'h31, 4'h1, r);
		check_resp("led write 1", soc_pkg::OKAY, r);
		check_led("led after 1", 3'b011, led);
		axil_write(`SOC_UART_DATA, 32'h0a, 4'h1, r);
		check_resp("led write LF", soc_pkg::OKAY, r);
		check_led("led after LF", 3'b111, led);
		axil_read(`SOC_UART_STAT, d, r);
		check_resp("led status read", soc_pkg::OKAY, r);
		check_led("led status bits", 3'b111, soc_pkg::led_t'(d[4:2]));
		apply_reset();
		check_led("led after reset", 3'b000, led);
		axil_read(`SOC_UART_STAT, d, r);
		check_resp("led status read after reset", soc_pkg::OKAY, r);
		check_led("led status after reset", 3'b000, soc_pkg::led_t'(d[4:2]));
	endtask

	////////////////////////////////////////
	// Run and watchdog
	////////////////////////////////////////

	initial begin
		rst = 1'b1;
		axil_req = '0;
		void'($urandom(SEED));
		fork
			begin
				apply_reset();
				test_ram_access();
				test_addr_errors();
				test_serial_frame();
				test_back_pressure();
				test_status_flags();
				test_led_flags();
			end
			begin
				#(WATCHDOG_NS);
				$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
				$display("Checks failed");
				$fatal(1, "watchdog expired");
			end
		join_any
		$display("All checks passed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+src
src/soc_pkg.sv
src/axil_slave_port.sv
src/mem_map_unit.sv
src/data_ram.sv
src/uart_tx_fifo.sv
src/char_led_monitor.sv
src/soc_top.sv
tb/soc_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module soc_tb -f filelist.f -o soc_sim \
	&& ./obj_dir/soc_sim 2>&1 | tee sim.log

grep -qx "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
